// ==== pcim_pkg.sv ====
/*
 shared widths, depths and encodings for the PCIe master host-memory
 responder. referenced by scoped name from the RTL and the testbench
*/
package pcim_pkg;

   localparam int DATA_W    = 64;
   localparam int STRB_W    = DATA_W / 8;
   localparam int ADDR_W    = 32;
   localparam int BEAT_OFS  = 3;   // byte bits below the beat index
   localparam int ID_W      = 5;
   localparam int LEN_W     = 8;   // beats minus one
   localparam int MEM_BEATS = 256;
   localparam int MEM_IDX_W = 8;
   localparam int CMD_DEPTH = 4;
   localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
   localparam int CMD_CNT_W = CMD_PTR_W + 1;

   // command queue entry widths
   localparam int WR_CMD_W  = ID_W + MEM_IDX_W + LEN_W;
   localparam int RD_CMD_W  = ID_W + MEM_IDX_W + LEN_W;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } axi_resp_e;

   typedef enum logic {WR_IDLE, WR_DATA} wr_state_e;

   typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_SEND} rd_state_e;

endpackage

// ==== cmd_fifo.sv ====
/*
 small circular FIFO for burst commands and pending response ids.
 the head entry is visible on dout_o before it is popped
*/
`timescale 1ns/1ps

module cmd_fifo #(
   parameter int WIDTH = 8
) (
   input  logic             clk_core,
   input  logic             sync_rst_n,
   input  logic             push_i,
   input  logic [WIDTH-1:0] din_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] dout_o,
   output logic             full_o,
   output logic             empty_o
);

   logic [WIDTH-1:0]               entry_q [pcim_pkg::CMD_DEPTH];
   logic [pcim_pkg::CMD_PTR_W-1:0] wr_ptr_q;
   logic [pcim_pkg::CMD_PTR_W-1:0] rd_ptr_q;
   logic [pcim_pkg::CMD_CNT_W-1:0] count_q;

   always_ff @(posedge clk_core or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i)
            wr_ptr_q <= wr_ptr_q + 1'b1;   // depth is a power of two, wraps
         if (pop_i)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (push_i && !pop_i)
            count_q <= count_q + 1'b1;
         else if (pop_i && !push_i)
            count_q <= count_q - 1'b1;
      end
   end

   always_ff @(posedge clk_core) begin
      if (push_i)
         entry_q[wr_ptr_q] <= din_i;
   end

   assign dout_o  = entry_q[rd_ptr_q];
   assign full_o  = (count_q == pcim_pkg::CMD_CNT_W'(pcim_pkg::CMD_DEPTH));
   assign empty_o = (count_q == '0);

endmodule

// ==== host_mem.sv ====
/*
 on-chip host memory, one data beat per entry. byte-strobed write port,
 read port with one cycle latency. rvalid_o flags beats already written
*/
`timescale 1ns/1ps

module host_mem (
   input  logic                             clk_core,
   input  logic                             sync_rst_n,
   input  logic                             we_i,
   input  logic [pcim_pkg::MEM_IDX_W-1:0]   widx_i,
   input  logic [pcim_pkg::DATA_W-1:0]      wdata_i,
   input  logic [pcim_pkg::STRB_W-1:0]      wstrb_i,
   input  logic                             re_i,
   input  logic [pcim_pkg::MEM_IDX_W-1:0]   ridx_i,
   output logic [pcim_pkg::DATA_W-1:0]      rdata_o,
   output logic                             rvalid_o
);

   logic [pcim_pkg::DATA_W-1:0]    mem_q [pcim_pkg::MEM_BEATS];
   logic [pcim_pkg::MEM_BEATS-1:0] written_q;

   // byte lanes under strobe
   always_ff @(posedge clk_core) begin
      if (we_i) begin
         for (int b = 0; b < pcim_pkg::STRB_W; b++) begin
            if (wstrb_i[b])
               mem_q[widx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
         end
      end
      if (re_i)
         rdata_o <= mem_q[ridx_i];
   end

   always_ff @(posedge clk_core or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         written_q <= '0;
         rvalid_o  <= 1'b0;
      end else begin
         if (we_i)
            written_q[widx_i] <= 1'b1;
         if (re_i)
            rvalid_o <= written_q[ridx_i];   // old flag on same-cycle write
      end
   end

endmodule

// ==== pcim_wr_ctrl.sv ====
/*
 write side of the host-memory responder. queues write commands, merges
 data beats into memory and returns one in-order response per burst
*/
`timescale 1ns/1ps

module pcim_wr_ctrl (
   input  logic                             clk_core,
   input  logic                             sync_rst_n,
   input  logic [pcim_pkg::ID_W-1:0]        awid_i,
   input  logic [pcim_pkg::ADDR_W-1:0]      awaddr_i,
   input  logic [pcim_pkg::LEN_W-1:0]       awlen_i,
   input  logic                             awvalid_i,
   output logic                             awready_o,
   input  logic [pcim_pkg::DATA_W-1:0]      wdata_i,
   input  logic [pcim_pkg::STRB_W-1:0]      wstrb_i,
   input  logic                             wlast_i,
   input  logic                             wvalid_i,
   output logic                             wready_o,
   output logic [pcim_pkg::ID_W-1:0]        bid_o,
   output logic [1:0]                       bresp_o,
   output logic                             bvalid_o,
   input  logic                             bready_i,
   output logic                             mem_we_o,
   output logic [pcim_pkg::MEM_IDX_W-1:0]   mem_widx_o,
   output logic [pcim_pkg::DATA_W-1:0]      mem_wdata_o,
   output logic [pcim_pkg::STRB_W-1:0]      mem_wstrb_o
);

   logic [pcim_pkg::WR_CMD_W-1:0]  cmd_din;
   logic [pcim_pkg::WR_CMD_W-1:0]  cmd_dout;
   logic                           cmd_push;
   logic                           cmd_pop;
   logic                           cmd_full;
   logic                           cmd_empty;
   logic                           rsp_push;
   logic                           rsp_pop;
   logic                           rsp_full;
   logic                           rsp_empty;
   logic [pcim_pkg::ID_W-1:0]      head_id;
   logic [pcim_pkg::MEM_IDX_W-1:0] head_idx;
   logic [pcim_pkg::LEN_W-1:0]     head_len;
   pcim_pkg::wr_state_e            state_q;
   logic [pcim_pkg::MEM_IDX_W-1:0] beat_idx_q;
   logic [pcim_pkg::LEN_W-1:0]     beats_left_q;
   logic [pcim_pkg::MEM_IDX_W-1:0] cur_idx;
   logic [pcim_pkg::LEN_W-1:0]     cur_left;
   logic                           beat_acc;
   logic                           burst_end;

   // ----------------------------------------
   // command and response queues
   // ----------------------------------------
   assign cmd_din  = {awid_i, awaddr_i[pcim_pkg::BEAT_OFS +: pcim_pkg::MEM_IDX_W], awlen_i};
   assign {head_id, head_idx, head_len} = cmd_dout;
   assign cmd_push = awvalid_i && awready_o;
   assign cmd_pop  = beat_acc && burst_end;
   assign rsp_push = cmd_pop;
   assign rsp_pop  = bvalid_o && bready_i;

   cmd_fifo #(.WIDTH(pcim_pkg::WR_CMD_W)) wr_cmd_fifo_i (
      .clk_core   (clk_core),
      .sync_rst_n (sync_rst_n),
      .push_i     (cmd_push),
      .din_i      (cmd_din),
      .pop_i      (cmd_pop),
      .dout_o     (cmd_dout),
      .full_o     (cmd_full),
      .empty_o    (cmd_empty)
   );

   cmd_fifo #(.WIDTH(pcim_pkg::ID_W)) wr_rsp_fifo_i (
      .clk_core   (clk_core),
      .sync_rst_n (sync_rst_n),
      .push_i     (rsp_push),
      .din_i      (head_id),
      .pop_i      (rsp_pop),
      .dout_o     (bid_o),
      .full_o     (rsp_full),
      .empty_o    (rsp_empty)
   );

   assign awready_o = !cmd_full;
   assign wready_o  = !cmd_empty && !rsp_full;   // data needs a command at the head
   assign bvalid_o  = !rsp_empty;
   assign bresp_o   = pcim_pkg::RESP_OKAY;

   // ----------------------------------------
   // data beats into memory
   // ----------------------------------------
   assign beat_acc  = wvalid_i && wready_o;
   assign cur_idx   = (state_q == pcim_pkg::WR_IDLE) ? head_idx : beat_idx_q;
   assign cur_left  = (state_q == pcim_pkg::WR_IDLE) ? head_len : beats_left_q;
   assign burst_end = wlast_i || (cur_left == '0);   // also closes on awlen count

   assign mem_we_o    = beat_acc;
   assign mem_widx_o  = cur_idx;
   assign mem_wdata_o = wdata_i;
   assign mem_wstrb_o = wstrb_i;

   always_ff @(posedge clk_core or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state_q <= pcim_pkg::WR_IDLE;
      end else if (beat_acc) begin
         state_q <= burst_end ? pcim_pkg::WR_IDLE : pcim_pkg::WR_DATA;
      end
   end

   always_ff @(posedge clk_core) begin
      if (beat_acc) begin
         beat_idx_q   <= cur_idx + 1'b1;
         beats_left_q <= cur_left - 1'b1;
      end
   end

endmodule

// ==== pcim_rd_ctrl.sv ====
/*
 read side of the host-memory responder. queues read commands and streams
 each burst beat by beat, unwritten beats come back as all ones
*/
`timescale 1ns/1ps

module pcim_rd_ctrl (
   input  logic                             clk_core,
   input  logic                             sync_rst_n,
   input  logic [pcim_pkg::ID_W-1:0]        arid_i,
   input  logic [pcim_pkg::ADDR_W-1:0]      araddr_i,
   input  logic [pcim_pkg::LEN_W-1:0]       arlen_i,
   input  logic                             arvalid_i,
   output logic                             arready_o,
   output logic [pcim_pkg::ID_W-1:0]        rid_o,
   output logic [pcim_pkg::DATA_W-1:0]      rdata_o,
   output logic [1:0]                       rresp_o,
   output logic                             rlast_o,
   output logic                             rvalid_o,
   input  logic                             rready_i,
   output logic                             mem_re_o,
   output logic [pcim_pkg::MEM_IDX_W-1:0]   mem_ridx_o,
   input  logic [pcim_pkg::DATA_W-1:0]      mem_rdata_i,
   input  logic                             mem_rvalid_i
);

   logic [pcim_pkg::RD_CMD_W-1:0]  cmd_din;
   logic [pcim_pkg::RD_CMD_W-1:0]  cmd_dout;
   logic                           cmd_push;
   logic                           cmd_pop;
   logic                           cmd_full;
   logic                           cmd_empty;
   logic [pcim_pkg::ID_W-1:0]      head_id;
   logic [pcim_pkg::MEM_IDX_W-1:0] head_idx;
   logic [pcim_pkg::LEN_W-1:0]     head_len;
   pcim_pkg::rd_state_e            state_q;
   logic [pcim_pkg::MEM_IDX_W-1:0] beat_idx_q;
   logic [pcim_pkg::LEN_W-1:0]     beats_left_q;
   logic [pcim_pkg::MEM_IDX_W-1:0] next_idx;
   logic                           send_next;

   assign cmd_din   = {arid_i, araddr_i[pcim_pkg::BEAT_OFS +: pcim_pkg::MEM_IDX_W], arlen_i};
   assign {head_id, head_idx, head_len} = cmd_dout;
   assign cmd_push  = arvalid_i && arready_o;
   assign arready_o = !cmd_full;

   cmd_fifo #(.WIDTH(pcim_pkg::RD_CMD_W)) rd_cmd_fifo_i (
      .clk_core   (clk_core),
      .sync_rst_n (sync_rst_n),
      .push_i     (cmd_push),
      .din_i      (cmd_din),
      .pop_i      (cmd_pop),
      .dout_o     (cmd_dout),
      .full_o     (cmd_full),
      .empty_o    (cmd_empty)
   );

   // ----------------------------------------
   // memory fetch
   // ----------------------------------------
   assign next_idx  = beat_idx_q + 1'b1;
   assign send_next = (state_q == pcim_pkg::RD_SEND) && rready_i && !rlast_o;
   assign cmd_pop   = (state_q == pcim_pkg::RD_SEND) && rready_i && rlast_o;
   assign rresp_o   = pcim_pkg::RESP_OKAY;

   assign mem_re_o   = ((state_q == pcim_pkg::RD_IDLE) && !cmd_empty) || send_next;
   assign mem_ridx_o = (state_q == pcim_pkg::RD_IDLE) ? head_idx : next_idx;

   always_ff @(posedge clk_core) begin
      if (state_q == pcim_pkg::RD_IDLE) begin
         beat_idx_q   <= head_idx;
         beats_left_q <= head_len;
      end else if (send_next) begin
         beat_idx_q   <= next_idx;
         beats_left_q <= beats_left_q - 1'b1;
      end
      if (state_q == pcim_pkg::RD_FETCH) begin
         rdata_o <= mem_rvalid_i ? mem_rdata_i : '1;   // never written
         rid_o   <= head_id;
      end
   end

   // ----------------------------------------
   // beat FSM
   // ----------------------------------------
   always_ff @(posedge clk_core or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state_q  <= pcim_pkg::RD_IDLE;
         rvalid_o <= 1'b0;
         rlast_o  <= 1'b0;
      end else begin
         case (state_q)
            pcim_pkg::RD_IDLE: begin
               if (!cmd_empty)
                  state_q <= pcim_pkg::RD_FETCH;
            end
            pcim_pkg::RD_FETCH: begin
               state_q  <= pcim_pkg::RD_SEND;
               rvalid_o <= 1'b1;
               rlast_o  <= (beats_left_q == '0);
            end
            pcim_pkg::RD_SEND: begin
               if (rready_i) begin
                  rvalid_o <= 1'b0;
                  rlast_o  <= 1'b0;
                  state_q  <= rlast_o ? pcim_pkg::RD_IDLE : pcim_pkg::RD_FETCH;
               end
            end
            default: state_q <= pcim_pkg::RD_IDLE;
         endcase
      end
   end

endmodule

// ==== pcim_host_top.sv ====
/*
 host-memory responder for the PCIe master path. the write and read
 controllers share one host memory. instantiate as the DUT
*/
`timescale 1ns/1ps

module pcim_host_top (
   input  logic                             clk_core,
   input  logic                             sync_rst_n,
   // write address
   input  logic [pcim_pkg::ID_W-1:0]        awid_i,
   input  logic [pcim_pkg::ADDR_W-1:0]      awaddr_i,
   input  logic [pcim_pkg::LEN_W-1:0]       awlen_i,
   input  logic                             awvalid_i,
   output logic                             awready_o,
   // write data
   input  logic [pcim_pkg::DATA_W-1:0]      wdata_i,
   input  logic [pcim_pkg::STRB_W-1:0]      wstrb_i,
   input  logic                             wlast_i,
   input  logic                             wvalid_i,
   output logic                             wready_o,
   // write response
   output logic [pcim_pkg::ID_W-1:0]        bid_o,
   output logic [1:0]                       bresp_o,
   output logic                             bvalid_o,
   input  logic                             bready_i,
   // read address
   input  logic [pcim_pkg::ID_W-1:0]        arid_i,
   input  logic [pcim_pkg::ADDR_W-1:0]      araddr_i,
   input  logic [pcim_pkg::LEN_W-1:0]       arlen_i,
   input  logic                             arvalid_i,
   output logic                             arready_o,
   // read data
   output logic [pcim_pkg::ID_W-1:0]        rid_o,
   output logic [pcim_pkg::DATA_W-1:0]      rdata_o,
   output logic [1:0]                       rresp_o,
   output logic                             rlast_o,
   output logic                             rvalid_o,
   input  logic                             rready_i
);

   logic                           mem_we;
   logic [pcim_pkg::MEM_IDX_W-1:0] mem_widx;
   logic [pcim_pkg::DATA_W-1:0]    mem_wdata;
   logic [pcim_pkg::STRB_W-1:0]    mem_wstrb;
   logic                           mem_re;
   logic [pcim_pkg::MEM_IDX_W-1:0] mem_ridx;
   logic [pcim_pkg::DATA_W-1:0]    mem_rdata;
   logic                           mem_rvalid;

   pcim_wr_ctrl pcim_wr_ctrl_i (
      .clk_core    (clk_core),
      .sync_rst_n  (sync_rst_n),
      .awid_i      (awid_i),
      .awaddr_i    (awaddr_i),
      .awlen_i     (awlen_i),
      .awvalid_i   (awvalid_i),
      .awready_o   (awready_o),
      .wdata_i     (wdata_i),
      .wstrb_i     (wstrb_i),
      .wlast_i     (wlast_i),
      .wvalid_i    (wvalid_i),
      .wready_o    (wready_o),
      .bid_o       (bid_o),
      .bresp_o     (bresp_o),
      .bvalid_o    (bvalid_o),
      .bready_i    (bready_i),
      .mem_we_o    (mem_we),
      .mem_widx_o  (mem_widx),
      .mem_wdata_o (mem_wdata),
      .mem_wstrb_o (mem_wstrb)
   );

   // shared between both paths
   host_mem host_mem_i (
      .clk_core   (clk_core),
      .sync_rst_n (sync_rst_n),
      .we_i       (mem_we),
      .widx_i     (mem_widx),
      .wdata_i    (mem_wdata),
      .wstrb_i    (mem_wstrb),
      .re_i       (mem_re),
      .ridx_i     (mem_ridx),
      .rdata_o    (mem_rdata),
      .rvalid_o   (mem_rvalid)
   );

   pcim_rd_ctrl pcim_rd_ctrl_i (
      .clk_core     (clk_core),
      .sync_rst_n   (sync_rst_n),
      .arid_i       (arid_i),
      .araddr_i     (araddr_i),
      .arlen_i      (arlen_i),
      .arvalid_i    (arvalid_i),
      .arready_o    (arready_o),
      .rid_o        (rid_o),
      .rdata_o      (rdata_o),
      .rresp_o      (rresp_o),
      .rlast_o      (rlast_o),
      .rvalid_o     (rvalid_o),
      .rready_i     (rready_i),
      .mem_re_o     (mem_re),
      .mem_ridx_o   (mem_ridx),
      .mem_rdata_i  (mem_rdata),
      .mem_rvalid_i (mem_rvalid)
   );

endmodule

// ==== pcim_props.sv ====
/*
 handshake assertions for the host-memory responder, bound to the
 top level. holds response payloads stable and checks rlast framing
*/
`timescale 1ns/1ps

module pcim_props (
   input  logic                        clk_core,
   input  logic                        sync_rst_n,
   input  logic                        bvalid_i,
   input  logic                        bready_i,
   input  logic [pcim_pkg::ID_W-1:0]   bid_i,
   input  logic [1:0]                  bresp_i,
   input  logic                        rvalid_i,
   input  logic                        rready_i,
   input  logic [pcim_pkg::ID_W-1:0]   rid_i,
   input  logic [pcim_pkg::DATA_W-1:0] rdata_i,
   input  logic [1:0]                  rresp_i,
   input  logic                        rlast_i
);

   int fail_cnt = 0;   // read by the testbench at the end

   b_hold: assert property (@(posedge clk_core) disable iff (!sync_rst_n)
      bvalid_i && !bready_i |=> bvalid_i && $stable(bid_i) && $stable(bresp_i))
      else begin
         $error("write response dropped or changed before bready");
         fail_cnt++;
      end

   r_hold: assert property (@(posedge clk_core) disable iff (!sync_rst_n)
      rvalid_i && !rready_i |=> rvalid_i && $stable(rid_i) && $stable(rdata_i)
                                && $stable(rresp_i) && $stable(rlast_i))
      else begin
         $error("read beat dropped or changed before rready");
         fail_cnt++;
      end

   r_last: assert property (@(posedge clk_core) disable iff (!sync_rst_n)
      rlast_i |-> rvalid_i)
      else begin
         $error("rlast high without rvalid");
         fail_cnt++;
      end

endmodule

bind pcim_host_top pcim_props pcim_props_i (
   .clk_core   (clk_core),
   .sync_rst_n (sync_rst_n),
   .bvalid_i   (bvalid_o),
   .bready_i   (bready_i),
   .bid_i      (bid_o),
   .bresp_i    (bresp_o),
   .rvalid_i   (rvalid_o),
   .rready_i   (rready_i),
   .rid_i      (rid_o),
   .rdata_i    (rdata_o),
   .rresp_i    (rresp_o),
   .rlast_i    (rlast_o)
);

// ==== pcim_checker.sv ====
/*
 testbench monitor. rebuilds host memory from observed write transfers
 and compares every write response and read beat against it
*/
`timescale 1ns/1ps

module pcim_checker (
   input  logic                          clk_core,
   input  logic                          sync_rst_n,
   input  logic [pcim_pkg::ID_W-1:0]     awid_i,
   input  logic [pcim_pkg::ADDR_W-1:0]   awaddr_i,
   input  logic [pcim_pkg::LEN_W-1:0]    awlen_i,
   input  logic                          awvalid_i,
   input  logic                          awready_i,
   input  logic [pcim_pkg::DATA_W-1:0]   wdata_i,
   input  logic [pcim_pkg::STRB_W-1:0]   wstrb_i,
   input  logic                          wlast_i,
   input  logic                          wvalid_i,
   input  logic                          wready_i,
   input  logic [pcim_pkg::ID_W-1:0]     bid_i,
   input  logic [1:0]                    bresp_i,
   input  logic                          bvalid_i,
   input  logic                          bready_i,
   input  logic [pcim_pkg::ID_W-1:0]     arid_i,
   input  logic [pcim_pkg::ADDR_W-1:0]   araddr_i,
   input  logic [pcim_pkg::LEN_W-1:0]    arlen_i,
   input  logic                          arvalid_i,
   input  logic                          arready_i,
   input  logic [pcim_pkg::ID_W-1:0]     rid_i,
   input  logic [pcim_pkg::DATA_W-1:0]   rdata_i,
   input  logic [1:0]                    rresp_i,
   input  logic                          rlast_i,
   input  logic                          rvalid_i,
   input  logic                          rready_i,
   output int                            err_cnt_o,
   output int                            wr_done_o,
   output int                            rd_done_o
);

   typedef struct packed {
      logic [pcim_pkg::ID_W-1:0]      id;
      logic [pcim_pkg::MEM_IDX_W-1:0] idx;
      logic [pcim_pkg::LEN_W-1:0]     len;
   } burst_t;

   burst_t                      aw_q[$];
   burst_t                      ar_q[$];
   logic [pcim_pkg::ID_W-1:0]   bid_q[$];
   logic [pcim_pkg::DATA_W-1:0] shadow [pcim_pkg::MEM_BEATS];
   bit                          written [pcim_pkg::MEM_BEATS];
   int                          errs = 0;
   int                          wr_done = 0;
   int                          rd_done = 0;
   int                          w_beat = 0;
   int                          r_beat = 0;
   bit                          rst_chk = 0;

   assign err_cnt_o = errs;
   assign wr_done_o = wr_done;
   assign rd_done_o = rd_done;

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
         errs++;
      end
   endtask

   always @(posedge clk_core) begin : watch
      logic [pcim_pkg::MEM_IDX_W-1:0] beat;
      logic [pcim_pkg::DATA_W-1:0]    exp_data;
      bit                             exp_last;
      if (!sync_rst_n) begin
         rst_chk = 1'b1;
      end else begin
         if (rst_chk) begin   // first edge out of reset
            compare("bvalid_o", 64'(bvalid_i), 64'd0);
            compare("rvalid_o", 64'(rvalid_i), 64'd0);
            compare("awready_o", 64'(awready_i), 64'd1);
            compare("arready_o", 64'(arready_i), 64'd1);
            rst_chk = 1'b0;
         end
         if (awvalid_i && awready_i)
            aw_q.push_back('{awid_i, awaddr_i[pcim_pkg::BEAT_OFS +: pcim_pkg::MEM_IDX_W],
                             awlen_i});
         // ----------------------------------------
         // write data into the shadow
         // ----------------------------------------
         if (wvalid_i && wready_i) begin
            if (aw_q.size() == 0) begin
               $display("write data accepted at %0t with no write command queued", $time);
               errs++;
            end else begin
               beat = aw_q[0].idx + pcim_pkg::MEM_IDX_W'(w_beat);
               for (int b = 0; b < pcim_pkg::STRB_W; b++)
                  if (wstrb_i[b])
                     shadow[beat][b*8 +: 8] = wdata_i[b*8 +: 8];
               written[beat] = 1'b1;
               if (wlast_i) begin
                  bid_q.push_back(aw_q[0].id);
                  aw_q.pop_front();
                  w_beat = 0;
               end else begin
                  w_beat++;
               end
            end
         end
         if (bvalid_i && bready_i) begin
            if (bid_q.size() == 0) begin
               $display("write response at %0t with no write burst outstanding", $time);
               errs++;
            end else begin
               compare("bid_o", 64'(bid_i), 64'(bid_q[0]));
               bid_q.pop_front();
            end
            compare("bresp_o", 64'(bresp_i), 64'(pcim_pkg::RESP_OKAY));
            wr_done++;
         end
         // ----------------------------------------
         // read beats against the shadow
         // ----------------------------------------
         if (rvalid_i && rready_i) begin
            if (ar_q.size() == 0) begin
               $display("read beat at %0t with no read burst outstanding", $time);
               errs++;
            end else begin
               beat     = ar_q[0].idx + pcim_pkg::MEM_IDX_W'(r_beat);
               exp_data = written[beat] ? shadow[beat] : '1;   // unwritten reads as ones
               exp_last = (r_beat == int'(ar_q[0].len));
               compare("rid_o", 64'(rid_i), 64'(ar_q[0].id));
               compare("rdata_o", rdata_i, exp_data);
               compare("rresp_o", 64'(rresp_i), 64'(pcim_pkg::RESP_OKAY));
               compare("rlast_o", 64'(rlast_i), 64'(exp_last));
               if (exp_last) begin
                  ar_q.pop_front();
                  r_beat = 0;
                  rd_done++;
               end else begin
                  r_beat++;
               end
            end
         end
         if (arvalid_i && arready_i)
            ar_q.push_back('{arid_i, araddr_i[pcim_pkg::BEAT_OFS +: pcim_pkg::MEM_IDX_W],
                             arlen_i});
      end
   end

endmodule

// ==== tb_pcim_host.sv ====
/*
 testbench top for the host-memory responder. runs a table of write and
 read bursts under random response back-pressure. the checker compares
*/
`timescale 1ns/1ps

module tb_pcim_host;

   localparam int TIMEOUT_CYC = 500;

   typedef enum logic {OP_WR, OP_RD} op_e;

   typedef struct packed {
      op_e                             op;
      logic [pcim_pkg::ADDR_W-1:0]     addr;
      logic [pcim_pkg::LEN_W-1:0]      len;
      logic [pcim_pkg::ID_W-1:0]       id;
      logic [pcim_pkg::DATA_W-1:0]     seed;
      logic [pcim_pkg::STRB_W-1:0]     strb;
      logic                            settle;   // wait for all bursts after this one
   } stim_t;

   logic                        clk_core;
   logic                        sync_rst_n;
   logic [pcim_pkg::ID_W-1:0]   awid_i;
   logic [pcim_pkg::ADDR_W-1:0] awaddr_i;
   logic [pcim_pkg::LEN_W-1:0]  awlen_i;
   logic                        awvalid_i;
   logic                        awready_o;
   logic [pcim_pkg::DATA_W-1:0] wdata_i;
   logic [pcim_pkg::STRB_W-1:0] wstrb_i;
   logic                        wlast_i;
   logic                        wvalid_i;
   logic                        wready_o;
   logic [pcim_pkg::ID_W-1:0]   bid_o;
   logic [1:0]                  bresp_o;
   logic                        bvalid_o;
   logic                        bready_i;
   logic [pcim_pkg::ID_W-1:0]   arid_i;
   logic [pcim_pkg::ADDR_W-1:0] araddr_i;
   logic [pcim_pkg::LEN_W-1:0]  arlen_i;
   logic                        arvalid_i;
   logic                        arready_o;
   logic [pcim_pkg::ID_W-1:0]   rid_o;
   logic [pcim_pkg::DATA_W-1:0] rdata_o;
   logic [1:0]                  rresp_o;
   logic                        rlast_o;
   logic                        rvalid_o;
   logic                        rready_i;

   stim_t stim[$];
   int    wr_issued = 0;
   int    rd_issued = 0;
   int    timeouts = 0;
   int    chk_errs;
   int    wr_done;
   int    rd_done;
   int    assert_errs;

   pcim_host_top pcim_host_top_i (.*);

   pcim_checker pcim_checker_i (
      .clk_core  (clk_core),   .sync_rst_n (sync_rst_n),
      .awid_i    (awid_i),     .awaddr_i   (awaddr_i),   .awlen_i   (awlen_i),
      .awvalid_i (awvalid_i),  .awready_i  (awready_o),
      .wdata_i   (wdata_i),    .wstrb_i    (wstrb_i),    .wlast_i   (wlast_i),
      .wvalid_i  (wvalid_i),   .wready_i   (wready_o),
      .bid_i     (bid_o),      .bresp_i    (bresp_o),
      .bvalid_i  (bvalid_o),   .bready_i   (bready_i),
      .arid_i    (arid_i),     .araddr_i   (araddr_i),   .arlen_i   (arlen_i),
      .arvalid_i (arvalid_i),  .arready_i  (arready_o),
      .rid_i     (rid_o),      .rdata_i    (rdata_o),    .rresp_i   (rresp_o),
      .rlast_i   (rlast_o),    .rvalid_i   (rvalid_o),   .rready_i  (rready_i),
      .err_cnt_o (chk_errs),   .wr_done_o  (wr_done),    .rd_done_o (rd_done)
   );

   initial begin
      clk_core = 1'b0;
      forever #50 clk_core = ~clk_core;
   end

   // random response back-pressure
   initial begin
      bready_i = 1'b0;
      rready_i = 1'b0;
      void'($urandom(90));
      forever begin
         @(negedge clk_core);
         bready_i = ($urandom % 4) != 0;
         rready_i = ($urandom % 3) != 0;
      end
   end

   function automatic stim_t make_entry(input op_e op, input logic [31:0] addr,
                                        input logic [7:0] len, input logic [4:0] id,
                                        input logic [63:0] seed, input logic [7:0] strb,
                                        input logic settle);
      stim_t e;
      e.op     = op;
      e.addr   = addr;
      e.len    = len;
      e.id     = id;
      e.seed   = seed;
      e.strb   = strb;
      e.settle = settle;
      return e;
   endfunction

   task automatic load_table();
      stim.push_back(make_entry(OP_WR, 32'h040, 8'd0, 5'd1, 64'h0123_4567_89ab_cdef, 8'hff, 1));
      stim.push_back(make_entry(OP_RD, 32'h040, 8'd0, 5'd2, 64'h0, 8'h00, 1));
      stim.push_back(make_entry(OP_WR, 32'h045, 8'd0, 5'd3, 64'hdead_beef_cafe_f00d, 8'h0f, 1));
      stim.push_back(make_entry(OP_RD, 32'h040, 8'd0, 5'd4, 64'h0, 8'h00, 1));
      stim.push_back(make_entry(OP_WR, 32'h100, 8'd3, 5'd5, 64'h1000_0000_0000_1000, 8'hff, 1));
      stim.push_back(make_entry(OP_RD, 32'h100, 8'd3, 5'd6, 64'h0, 8'h00, 1));
      stim.push_back(make_entry(OP_RD, 32'h400, 8'd1, 5'd7, 64'h0, 8'h00, 1));   // never written
      stim.push_back(make_entry(OP_WR, 32'h200, 8'd7, 5'd8, 64'h2222_0000_0000_0000, 8'hff, 1));
      // several reads queued at once
      stim.push_back(make_entry(OP_RD, 32'h200, 8'd7, 5'd9, 64'h0, 8'h00, 0));
      stim.push_back(make_entry(OP_RD, 32'h100, 8'd3, 5'd10, 64'h0, 8'h00, 0));
      stim.push_back(make_entry(OP_RD, 32'h040, 8'd0, 5'd11, 64'h0, 8'h00, 0));
      stim.push_back(make_entry(OP_RD, 32'h600, 8'd2, 5'd12, 64'h0, 8'h00, 0));
      stim.push_back(make_entry(OP_RD, 32'h208, 8'd1, 5'd13, 64'h0, 8'h00, 1));
      stim.push_back(make_entry(OP_WR, 32'h300, 8'd1, 5'd14, 64'h3000_0000_0000_0000, 8'hff, 0));
      stim.push_back(make_entry(OP_WR, 32'h310, 8'd1, 5'd15, 64'h3100_0000_0000_0000, 8'hf0, 0));
      stim.push_back(make_entry(OP_WR, 32'h320, 8'd0, 5'd16, 64'h3200_0000_0000_0000, 8'hff, 1));
      stim.push_back(make_entry(OP_RD, 32'h300, 8'd4, 5'd17, 64'h0, 8'h00, 1));
   endtask

   function automatic logic chan_ready(input int chan);
      case (chan)
         0:       return awready_o;
         1:       return wready_o;
         default: return arready_o;
      endcase
   endfunction

   // returns on the edge that completes the transfer
   task automatic await_ready(input int chan, input string what);
      int n;
      n = 0;
      @(posedge clk_core);
      while (!chan_ready(chan) && n < TIMEOUT_CYC) begin
         @(posedge clk_core);
         n++;
      end
      if (!chan_ready(chan)) begin
         $display("timeout at %0t waiting for %s", $time, what);
         timeouts++;
      end
   endtask

   task automatic write_burst(input stim_t e);
      @(negedge clk_core);
      awid_i    = e.id;
      awaddr_i  = e.addr;
      awlen_i   = e.len;
      awvalid_i = 1'b1;
      await_ready(0, "awready_o");
      for (int i = 0; i <= int'(e.len); i++) begin
         @(negedge clk_core);
         awvalid_i = 1'b0;
         wdata_i   = e.seed + 64'(i);
         wstrb_i   = e.strb;
         wlast_i   = (i == int'(e.len));
         wvalid_i  = 1'b1;
         await_ready(1, "wready_o");
      end
      @(negedge clk_core);
      wvalid_i = 1'b0;
      wlast_i  = 1'b0;
      wr_issued++;
   endtask

   task automatic read_burst(input stim_t e);
      @(negedge clk_core);
      arid_i    = e.id;
      araddr_i  = e.addr;
      arlen_i   = e.len;
      arvalid_i = 1'b1;
      await_ready(2, "arready_o");
      @(negedge clk_core);
      arvalid_i = 1'b0;
      rd_issued++;
   endtask

   task automatic settle_all();
      int n;
      n = 0;
      while ((wr_done != wr_issued || rd_done != rd_issued) && n < TIMEOUT_CYC) begin
         @(negedge clk_core);
         n++;
      end
      if (wr_done != wr_issued || rd_done != rd_issued) begin
         $display("timeout at %0t: %0d of %0d write and %0d of %0d read bursts done",
                  $time, wr_done, wr_issued, rd_done, rd_issued);
         timeouts++;
      end
   endtask

   initial begin
      sync_rst_n = 1'b0;
      awid_i     = '0;
      awaddr_i   = '0;
      awlen_i    = '0;
      awvalid_i  = 1'b0;
      wdata_i    = '0;
      wstrb_i    = '0;
      wlast_i    = 1'b0;
      wvalid_i   = 1'b0;
      arid_i     = '0;
      araddr_i   = '0;
      arlen_i    = '0;
      arvalid_i  = 1'b0;
      load_table();
      repeat (4) @(posedge clk_core);
      @(negedge clk_core);
      sync_rst_n = 1'b1;
      @(negedge clk_core);
      foreach (stim[k]) begin
         if (stim[k].op == OP_WR)
            write_burst(stim[k]);
         else
            read_burst(stim[k]);
         if (stim[k].settle)
            settle_all();
      end
      settle_all();
      assert_errs = pcim_host_top_i.pcim_props_i.fail_cnt;
      $display("errors: %0d check, %0d timeout, %0d assertion",
               chk_errs, timeouts, assert_errs);
      if (chk_errs + timeouts + assert_errs == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== sources.f ====
pcim_pkg.sv
cmd_fifo.sv
host_mem.sv
pcim_wr_ctrl.sv
pcim_rd_ctrl.sv
pcim_host_top.sv
pcim_props.sv
pcim_checker.sv
tb_pcim_host.sv

// ==== Makefile ====
SIM  = obj_dir/Vtb_pcim_host
SRCS = $(wildcard *.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) sources.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pcim_host \
		-f sources.f -o Vtb_pcim_host

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	! grep -q "Simulation failed" sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
